//--- Bender.yml
package:
  name: x86_front_end

sources:
  - rtl/x86_decode_pkg.sv
  - rtl/decode_if.sv
  - rtl/predecode.sv
  - rtl/operand_decode.sv
  - rtl/register_file.sv
  - rtl/addr_gen.sv
  - rtl/pipeline.sv
  - target: simulation
    files:
      - tb/pipeline_chk.sv
      - tb/tb_pipeline.sv

//--- project.f
rtl/x86_decode_pkg.sv
rtl/decode_if.sv
rtl/predecode.sv
rtl/operand_decode.sv
rtl/register_file.sv
rtl/addr_gen.sv
rtl/pipeline.sv
tb/pipeline_chk.sv
tb/tb_pipeline.sv

//--- rtl/addr_gen.sv
`timescale 1ns/1ps

module addr_gen import x86_decode_pkg::*; (
   input  logic        CLK,
   input  logic        rst_n,
   operand_if.consumer o,
   output logic        out_valid,
   output logic        out_illegal,
   output opcode_t     out_opcode,
   output ilen_t       out_length,
   output word_t       out_next_eip,
   output word_t       out_a,
   output word_t       out_b,
   output logic        out_mem_rd,
   output logic        out_mem_wr,
   output word_t       out_mem_addr,
   output reg_id_t     out_dr
);

   word_t base_term;
   word_t index_term;
   word_t ea;
   logic  mem_req;

   assign base_term  = o.base_en ? o.base_val : '0;
   assign index_term = o.index_en ? (o.index_val << o.scale) : '0;
   // Wraps at 2^32
   assign ea         = base_term + index_term + o.disp;

   assign mem_req = o.valid && o.mem_op;

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         out_valid    <= 1'b0;
         out_mem_rd   <= 1'b0;
         out_mem_wr   <= 1'b0;
         out_mem_addr <= '0;
      end else begin
         out_valid    <= o.valid;
         // A plain store to memory needs no read of the old value
         out_mem_rd   <= mem_req && (o.opcode != OP_MOV_RM_R);
         out_mem_wr   <= mem_req && o.mem_wr;
         out_mem_addr <= mem_req ? ea : '0;
      end
   end

   always_ff @(posedge CLK) begin
      out_illegal  <= o.illegal;
      out_opcode   <= o.opcode;
      out_length   <= o.length;
      out_next_eip <= o.eip + word_t'(o.length);
      out_a        <= o.val_a;
      out_b        <= o.val_b;
      out_dr       <= o.dr;
   end

endmodule

//--- rtl/decode_if.sv
`timescale 1ns/1ps

// Predecode to operand decode
interface decode_if import x86_decode_pkg::*; ();
   logic        valid;
   ir_t         ir;
   word_t       eip;
   opcode_t     opcode;
   logic        illegal;
   logic        opsize_ovr;
   ilen_t       length;
   logic [7:0]  modrm;
   logic [7:0]  sib;
   logic        sib_present;
   modrm_kind_e modrm_kind;
   ilen_t       disp_start;
   ilen_t       imm_start;
   logic        imm_present;
   // Immediate size in bytes
   ilen_t       imm_size;

   modport producer (
      output valid, ir, eip, opcode, illegal, opsize_ovr, length,
      output modrm, sib, sib_present, modrm_kind, disp_start, imm_start,
      output imm_present, imm_size
   );

   modport consumer (
      input valid, ir, eip, opcode, illegal, opsize_ovr, length,
      input modrm, sib, sib_present, modrm_kind, disp_start, imm_start,
      input imm_present, imm_size
   );
endinterface

// Operand decode to address generation
interface operand_if import x86_decode_pkg::*; ();
   logic       valid;
   logic       illegal;
   opcode_t    opcode;
   ilen_t      length;
   word_t      eip;
   word_t      val_a;
   word_t      val_b;
   word_t      base_val;
   logic       base_en;
   word_t      index_val;
   logic       index_en;
   logic [1:0] scale;
   word_t      disp;
   logic       mem_op;
   logic       mem_wr;
   reg_id_t    dr;

   modport producer (
      output valid, illegal, opcode, length, eip, val_a, val_b,
      output base_val, base_en, index_val, index_en, scale, disp,
      output mem_op, mem_wr, dr
   );

   modport consumer (
      input valid, illegal, opcode, length, eip, val_a, val_b,
      input base_val, base_en, index_val, index_en, scale, disp,
      input mem_op, mem_wr, dr
   );
endinterface

//--- rtl/operand_decode.sv
`timescale 1ns/1ps

module operand_decode import x86_decode_pkg::*; (
   input  logic        CLK,
   input  logic        rst_n,
   decode_if.consumer  d,
   operand_if.producer o,
   output reg_id_t     rd_id_a,
   output reg_id_t     rd_id_b,
   output reg_id_t     rd_id_c,
   output reg_id_t     rd_id_d,
   input  word_t       rd_data_a,
   input  word_t       rd_data_b,
   input  word_t       rd_data_c,
   input  word_t       rd_data_d
);

   // Little-endian word starting at byte s
   function automatic word_t le_word(input ir_t w, input ilen_t s);
      return {ir_byte(w, s + 4'd3), ir_byte(w, s + 4'd2),
              ir_byte(w, s + 4'd1), ir_byte(w, s)};
   endfunction

   logic [1:0] mod_f;
   reg_id_t    reg_f;
   reg_id_t    rm_f;
   reg_id_t    sib_base;
   reg_id_t    sib_idx;
   logic       is_eax_imm;
   logic [7:0] disp8;
   word_t      disp_w;
   word_t      imm_raw;
   logic       imm_hi;
   word_t      imm_w;
   logic       mem_form;
   logic       no_base;
   logic       base_en;
   logic       index_en;
   logic       mem_wr;
   reg_id_t    dr;
   word_t      val_b;

   assign mod_f      = d.modrm[7:6];
   assign reg_f      = d.modrm[5:3];
   assign rm_f       = d.modrm[2:0];
   assign sib_base   = d.sib[2:0];
   assign sib_idx    = d.sib[5:3];
   assign is_eax_imm = (d.opcode == OP_ADD_EAX_IMM);

   assign disp8 = ir_byte(d.ir, d.disp_start);

   always_comb begin
      case (d.modrm_kind)
         MK_MEM_DISP8:  disp_w = {{24{disp8[7]}}, disp8};
         MK_MEM_DISP32: disp_w = le_word(d.ir, d.disp_start);
         default:       disp_w = '0;
      endcase
   end

   // imm16 is zero-extended
   assign imm_raw = le_word(d.ir, d.imm_start);
   assign imm_hi  = (d.imm_size == 4'd4) && !d.opsize_ovr;
   assign imm_w   = imm_hi ? imm_raw : {16'h0, imm_raw[15:0]};

   assign mem_form = !d.illegal && (d.modrm_kind != MK_REG);

   // mod 00 with rm or SIB base 101 has only a disp32
   assign no_base  = (mod_f == 2'b00) &&
                     (d.sib_present ? (sib_base == 3'b101) : (rm_f == 3'b101));
   assign base_en  = mem_form && !no_base;
   assign index_en = mem_form && d.sib_present && (sib_idx != 3'b100);

   assign rd_id_a = is_eax_imm ? 3'd0 : reg_f;
   assign rd_id_b = rm_f;
   assign rd_id_c = d.sib_present ? sib_base : rm_f;
   assign rd_id_d = sib_idx;

   always_comb begin
      if (d.imm_present) begin
         val_b = imm_w;
      end else if ((mod_f == 2'b11) && !is_eax_imm) begin
         val_b = rd_data_b;
      end else begin
         val_b = '0;
      end
   end

   always_comb begin
      mem_wr = 1'b0;
      dr     = 3'd0;
      case (d.opcode)
         OP_ADD_R_RM,
         OP_MOV_R_RM: dr = reg_f;
         OP_ADD_RM_R,
         OP_MOV_RM_R,
         OP_GRP1_IMM: begin
            dr     = rm_f;
            mem_wr = mem_form;
         end
         default: dr = 3'd0;
      endcase
   end

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         o.valid <= 1'b0;
      end else begin
         o.valid <= d.valid;
      end
   end

   always_ff @(posedge CLK) begin
      o.illegal   <= d.illegal;
      o.opcode    <= d.opcode;
      o.length    <= d.length;
      o.eip       <= d.eip;
      o.val_a     <= rd_data_a;
      o.val_b     <= val_b;
      o.base_val  <= rd_data_c;
      o.base_en   <= base_en;
      o.index_val <= rd_data_d;
      o.index_en  <= index_en;
      o.scale     <= d.sib[7:6];
      o.disp      <= disp_w;
      o.mem_op    <= mem_form;
      o.mem_wr    <= mem_wr;
      o.dr        <= dr;
   end

endmodule

//--- rtl/pipeline.sv
`timescale 1ns/1ps

module pipeline import x86_decode_pkg::*; #(
   parameter int NUM_GPR = 8
) (
   input  logic    CLK,
   input  logic    rst_n,
   input  logic    ir_valid,
   input  ir_t     ir,
   input  word_t   ir_eip,
   input  logic    gpr_we,
   input  reg_id_t gpr_wr_id,
   input  word_t   gpr_din,
   output logic    out_valid,
   output logic    out_illegal,
   output opcode_t out_opcode,
   output ilen_t   out_length,
   output word_t   out_next_eip,
   output word_t   out_a,
   output word_t   out_b,
   output logic    out_mem_rd,
   output logic    out_mem_wr,
   output word_t   out_mem_addr,
   output reg_id_t out_dr
);

   decode_if  dec_bus ();
   operand_if opnd_bus ();

   reg_id_t rd_id_a;
   reg_id_t rd_id_b;
   reg_id_t rd_id_c;
   reg_id_t rd_id_d;
   word_t   rd_data_a;
   word_t   rd_data_b;
   word_t   rd_data_c;
   word_t   rd_data_d;

   predecode u_predecode (
      .CLK      (CLK),
      .rst_n    (rst_n),
      .ir_valid (ir_valid),
      .ir       (ir),
      .ir_eip   (ir_eip),
      .d        (dec_bus)
   );

   // Register reads happen in the operand decode cycle
   operand_decode u_operand_decode (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .d         (dec_bus),
      .o         (opnd_bus),
      .rd_id_a   (rd_id_a),
      .rd_id_b   (rd_id_b),
      .rd_id_c   (rd_id_c),
      .rd_id_d   (rd_id_d),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b),
      .rd_data_c (rd_data_c),
      .rd_data_d (rd_data_d)
   );

   register_file #(
      .NUM_GPR (NUM_GPR)
   ) u_register_file (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .rd_id_a   (rd_id_a),
      .rd_data_a (rd_data_a),
      .rd_id_b   (rd_id_b),
      .rd_data_b (rd_data_b),
      .rd_id_c   (rd_id_c),
      .rd_data_c (rd_data_c),
      .rd_id_d   (rd_id_d),
      .rd_data_d (rd_data_d),
      .we        (gpr_we),
      .wr_id     (gpr_wr_id),
      .din       (gpr_din)
   );

   addr_gen u_addr_gen (
      .CLK          (CLK),
      .rst_n        (rst_n),
      .o            (opnd_bus),
      .out_valid    (out_valid),
      .out_illegal  (out_illegal),
      .out_opcode   (out_opcode),
      .out_length   (out_length),
      .out_next_eip (out_next_eip),
      .out_a        (out_a),
      .out_b        (out_b),
      .out_mem_rd   (out_mem_rd),
      .out_mem_wr   (out_mem_wr),
      .out_mem_addr (out_mem_addr),
      .out_dr       (out_dr)
   );

endmodule

//--- rtl/predecode.sv
`timescale 1ns/1ps

module predecode import x86_decode_pkg::*; (
   input  logic       CLK,
   input  logic       rst_n,
   input  logic       ir_valid,
   input  ir_t        ir,
   input  word_t      ir_eip,
   decode_if.producer d
);

   logic        pfx;
   ilen_t       op_pos;
   opcode_t     opc;
   logic [7:0]  modrm;
   logic [7:0]  sib;
   logic        known;
   logic        has_modrm;
   logic        sib_pres;
   modrm_kind_e kind;
   ilen_t       disp_bytes;
   logic        imm_pres;
   ilen_t       imm_bytes;
   ilen_t       disp_start;
   ilen_t       imm_start;
   ilen_t       len;

   // Only one prefix byte can precede the opcode
   assign pfx    = (ir_byte(ir, 4'd0) == PFX_OPSIZE);
   assign op_pos = pfx ? 4'd1 : 4'd0;
   assign opc    = ir_byte(ir, op_pos);
   assign modrm  = ir_byte(ir, op_pos + 4'd1);
   assign sib    = ir_byte(ir, op_pos + 4'd2);

   always_comb begin
      case (opc)
         OP_ADD_RM_R,
         OP_ADD_R_RM,
         OP_MOV_RM_R,
         OP_MOV_R_RM,
         OP_GRP1_IMM,
         OP_ADD_EAX_IMM: known = 1'b1;
         default:        known = 1'b0;
      endcase
   end

   // 05 id carries its operand implicitly in EAX
   assign has_modrm = known && (opc != OP_ADD_EAX_IMM);
   assign sib_pres  = has_modrm && (modrm[7:6] != 2'b11) && (modrm[2:0] == 3'b100);

   always_comb begin
      if (!has_modrm) begin
         kind = MK_REG;
      end else begin
         case (modrm[7:6])
            2'b00: begin
               // Absolute disp32 either direct or through a SIB with no base
               if ((modrm[2:0] == 3'b101) || (sib_pres && (sib[2:0] == 3'b101))) begin
                  kind = MK_MEM_DISP32;
               end else begin
                  kind = MK_MEM_NODISP;
               end
            end
            2'b01:   kind = MK_MEM_DISP8;
            2'b10:   kind = MK_MEM_DISP32;
            default: kind = MK_REG;
         endcase
      end
   end

   always_comb begin
      case (kind)
         MK_MEM_DISP8:  disp_bytes = 4'd1;
         MK_MEM_DISP32: disp_bytes = 4'd4;
         default:       disp_bytes = 4'd0;
      endcase
   end

   assign imm_pres  = known && ((opc == OP_GRP1_IMM) || (opc == OP_ADD_EAX_IMM));
   assign imm_bytes = pfx ? 4'd2 : 4'd4;

   // Field offsets inside the window
   assign disp_start = op_pos + 4'd1 + ilen_t'(has_modrm) + ilen_t'(sib_pres);
   assign imm_start  = disp_start + disp_bytes;

   // Unknown opcodes consume the prefix and the opcode byte only
   assign len = known ? (imm_start + (imm_pres ? imm_bytes : 4'd0)) : (op_pos + 4'd1);

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         d.valid <= 1'b0;
      end else begin
         d.valid <= ir_valid;
      end
   end

   always_ff @(posedge CLK) begin
      d.ir          <= ir;
      d.eip         <= ir_eip;
      d.opcode      <= opc;
      d.illegal     <= !known;
      d.opsize_ovr  <= pfx;
      d.length      <= len;
      d.modrm       <= modrm;
      d.sib         <= sib;
      d.sib_present <= sib_pres;
      d.modrm_kind  <= kind;
      d.disp_start  <= disp_start;
      d.imm_start   <= imm_start;
      d.imm_present <= imm_pres;
      d.imm_size    <= imm_bytes;
   end

endmodule

//--- rtl/register_file.sv
`timescale 1ns/1ps

module register_file import x86_decode_pkg::*; #(
   parameter int NUM_GPR = 8
) (
   input  logic    CLK,
   input  logic    rst_n,
   input  reg_id_t rd_id_a,
   output word_t   rd_data_a,
   input  reg_id_t rd_id_b,
   output word_t   rd_data_b,
   input  reg_id_t rd_id_c,
   output word_t   rd_data_c,
   input  reg_id_t rd_id_d,
   output word_t   rd_data_d,
   input  logic    we,
   input  reg_id_t wr_id,
   input  word_t   din
);

   word_t gpr [NUM_GPR];

   // Write lands on the edge with no bypass to the read ports
   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_GPR; i++) begin
            gpr[i] <= '0;
         end
      end else if (we) begin
         gpr[wr_id] <= din;
      end
   end

   // Asynchronous reads
   assign rd_data_a = gpr[rd_id_a];
   assign rd_data_b = gpr[rd_id_b];
   assign rd_data_c = gpr[rd_id_c];
   assign rd_data_d = gpr[rd_id_d];

endmodule

//--- rtl/x86_decode_pkg.sv
package x86_decode_pkg;

   // Byte 0 of the fetch window sits in the top bits
   typedef logic [127:0] ir_t;
   typedef logic [31:0]  word_t;
   typedef logic [2:0]   reg_id_t;
   typedef logic [3:0]   ilen_t;
   typedef logic [7:0]   opcode_t;

   localparam opcode_t OP_ADD_RM_R    = 8'h01;
   localparam opcode_t OP_ADD_R_RM    = 8'h03;
   localparam opcode_t OP_MOV_RM_R    = 8'h89;
   localparam opcode_t OP_MOV_R_RM    = 8'h8B;
   localparam opcode_t OP_GRP1_IMM    = 8'h81;
   localparam opcode_t OP_ADD_EAX_IMM = 8'h05;

   // Operand size override shrinks imm32 to imm16
   localparam opcode_t PFX_OPSIZE     = 8'h66;

   // ModRM addressing class named by displacement size
   typedef enum logic [1:0] {
      MK_REG        = 2'd0,
      MK_MEM_NODISP = 2'd1,
      MK_MEM_DISP8  = 2'd2,
      MK_MEM_DISP32 = 2'd3
   } modrm_kind_e;

   // Byte idx of the window counted from the first fetched byte
   function automatic logic [7:0] ir_byte(input ir_t w, input ilen_t idx);
      return w[(15 - idx) * 8 +: 8];
   endfunction

endpackage

//--- tb/pipeline_chk.sv
`timescale 1ns/1ps

module pipeline_chk (
   input logic        CLK,
   input logic        rst_n,
   input logic        ir_valid,
   input logic        dec_valid,
   input logic        opnd_valid,
   input logic        out_valid,
   input logic        out_mem_rd,
   input logic        out_mem_wr,
   input logic [31:0] out_mem_addr
);

   // Fixed three stage latency with no stalls
   valid_latency: assert property (
      @(posedge CLK) disable iff (!rst_n)
      out_valid == $past(ir_valid, 3)
   ) else $error("out_valid does not follow ir_valid by three cycles");

   // Every stage is empty once a reset edge has passed
   valid_in_reset: assert property (
      @(posedge CLK)
      !rst_n |=> (!dec_valid && !opnd_valid && !out_valid)
   ) else $error("valid flag set after a reset edge");

   addr_idle_zero: assert property (
      @(posedge CLK) disable iff (!rst_n)
      (!out_mem_rd && !out_mem_wr) |-> (out_mem_addr == 32'h0)
   ) else $error("out_mem_addr nonzero without a memory access");

endmodule

//--- tb/tb_pipeline.sv
`timescale 1ns/1ps

module tb_pipeline import x86_decode_pkg::*; ();

   typedef struct packed {
      logic    illegal;
      opcode_t opcode;
      ilen_t   length;
      word_t   next_eip;
      word_t   a;
      word_t   b;
      logic    mem_rd;
      logic    mem_wr;
      word_t   mem_addr;
      reg_id_t dr;
      logic    chk_data;
   } exp_t;

   logic    CLK = 1'b0;
   logic    rst_n;
   logic    ir_valid;
   ir_t     ir;
   word_t   ir_eip;
   logic    gpr_we;
   reg_id_t gpr_wr_id;
   word_t   gpr_din;
   logic    out_valid;
   logic    out_illegal;
   opcode_t out_opcode;
   ilen_t   out_length;
   word_t   out_next_eip;
   word_t   out_a;
   word_t   out_b;
   logic    out_mem_rd;
   logic    out_mem_wr;
   word_t   out_mem_addr;
   reg_id_t out_dr;

   logic [15:0] lfsr;
   word_t       gpr_model [8];
   exp_t        exp_q [$];
   int          errors = 0;
   int          checks = 0;
   int          results = 0;
   int          issued = 0;
   logic        timed_out = 1'b0;

   always #10 CLK = ~CLK;

   pipeline #(.NUM_GPR(8)) DUT (.*);

   bind pipeline pipeline_chk u_chk (
      .CLK          (CLK),
      .rst_n        (rst_n),
      .ir_valid     (ir_valid),
      .dec_valid    (dec_bus.valid),
      .opnd_valid   (opnd_bus.valid),
      .out_valid    (out_valid),
      .out_mem_rd   (out_mem_rd),
      .out_mem_wr   (out_mem_wr),
      .out_mem_addr (out_mem_addr)
   );

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic logic is_known(input logic [7:0] op);
      return (op == 8'h01) || (op == 8'h03) || (op == 8'h89) ||
             (op == 8'h8B) || (op == 8'h81) || (op == 8'h05);
   endfunction

   // Random instruction of one class plus its expected result
   task automatic make_insn(input int kind, output ir_t w, output word_t eip, output exp_t e);
      logic [7:0] b [16];
      logic       pfx;
      logic [7:0] opc;
      logic [1:0] md;
      reg_id_t    rg;
      reg_id_t    rm;
      logic [7:0] sib;
      logic       has_modrm;
      logic       sib_pres;
      logic       mem;
      logic       base_en;
      logic       index_en;
      int         pos;
      int         disp_n;
      int         imm_n;
      word_t      disp;
      word_t      imm;
      word_t      ea;
      for (int i = 0; i < 16; i++) begin
         b[i] = 8'(rand_bits(8));
      end
      pfx = 1'(rand_bits(1));
      md  = 2'(rand_bits(2));
      rg  = reg_id_t'(rand_bits(3));
      rm  = reg_id_t'(rand_bits(3));
      sib = 8'(rand_bits(8));
      case (rand_bits(2))
         0: opc = 8'h01;
         1: opc = 8'h03;
         2: opc = 8'h89;
         default: opc = 8'h8B;
      endcase
      case (kind)
         1: md = 2'b11;
         2: begin
            if (md == 2'b11) md = 2'b00;
            if (rm == 3'b100) rm = 3'b101;
         end
         3: begin
            if (md == 2'b11) md = 2'(rand_bits(1));
            rm = 3'b100;
            // Some SIB forms take the no-base encoding
            if (rand_bits(2) == 0) begin
               md       = 2'b00;
               sib[2:0] = 3'b101;
            end
         end
         4: opc = rand_bits(1) ? 8'h81 : 8'h05;
         default: begin
            do opc = 8'(rand_bits(8)); while (is_known(opc) || (opc == 8'h66));
         end
      endcase
      eip      = rand_bits(32);
      e        = '0;
      e.opcode = opc;
      pos      = 0;
      if (pfx) begin
         b[pos] = 8'h66;
         pos++;
      end
      b[pos] = opc;
      pos++;
      if (kind == 5) begin
         e.illegal = 1'b1;
      end else begin
         has_modrm = (opc != 8'h05);
         sib_pres  = has_modrm && (md != 2'b11) && (rm == 3'b100);
         if (has_modrm) begin
            b[pos] = {md, rg, rm};
            pos++;
         end
         if (sib_pres) begin
            b[pos] = sib;
            pos++;
         end
         disp_n = 0;
         if (has_modrm && md == 2'b01) disp_n = 1;
         else if (has_modrm && md == 2'b10) disp_n = 4;
         else if (has_modrm && md == 2'b00 &&
                  (rm == 3'b101 || (sib_pres && sib[2:0] == 3'b101))) disp_n = 4;
         // Displacement and immediate are little endian in the byte stream
         if (disp_n == 1) disp = {{24{b[pos][7]}}, b[pos]};
         else if (disp_n == 4) disp = {b[pos+3], b[pos+2], b[pos+1], b[pos]};
         else disp = '0;
         pos += disp_n;
         imm_n = (opc == 8'h81 || opc == 8'h05) ? (pfx ? 2 : 4) : 0;
         if (imm_n == 4) imm = {b[pos+3], b[pos+2], b[pos+1], b[pos]};
         else if (imm_n == 2) imm = {16'h0, b[pos+1], b[pos]};
         else imm = '0;
         pos += imm_n;
         mem      = has_modrm && (md != 2'b11);
         base_en  = mem && !(md == 2'b00 && (sib_pres ? sib[2:0] == 3'b101 : rm == 3'b101));
         index_en = mem && sib_pres && (sib[5:3] != 3'b100);
         ea = disp;
         if (base_en) ea += gpr_model[sib_pres ? sib[2:0] : rm];
         if (index_en) ea += gpr_model[sib[5:3]] << sib[7:6];
         e.a        = gpr_model[(opc == 8'h05) ? 3'd0 : rg];
         e.b        = (imm_n != 0) ? imm : ((mem || !has_modrm) ? '0 : gpr_model[rm]);
         e.mem_rd   = mem && (opc != 8'h89);
         e.mem_wr   = mem && (opc == 8'h01 || opc == 8'h89 || opc == 8'h81);
         e.mem_addr = mem ? ea : '0;
         if (opc == 8'h03 || opc == 8'h8B) e.dr = rg;
         else if (opc == 8'h05) e.dr = 3'd0;
         else e.dr = rm;
         e.chk_data = 1'b1;
      end
      e.length   = 4'(pos);
      e.next_eip = eip + word_t'(pos);
      for (int i = 0; i < 16; i++) begin
         w[(15 - i) * 8 +: 8] = b[i];
      end
   endtask

   task automatic compare(input string name, input word_t got, input word_t want);
      checks++;
      if (got !== want) begin
         $display("FAILED %0t: %s is %h, expected %h", $time, name, got, want);
         errors++;
      end
   endtask

   // Scoreboard checks each result against the oldest expectation
   always @(negedge CLK) begin : scoreboard
      exp_t e;
      if (rst_n === 1'b1 && out_valid === 1'b1) begin
         results++;
         if (exp_q.size() == 0) begin
            $display("Result at %0t arrived with no instruction outstanding", $time);
            errors++;
         end else begin
            e = exp_q.pop_front();
            compare("out_illegal", word_t'(out_illegal), word_t'(e.illegal));
            compare("out_opcode", word_t'(out_opcode), word_t'(e.opcode));
            compare("out_length", word_t'(out_length), word_t'(e.length));
            compare("out_next_eip", out_next_eip, e.next_eip);
            compare("out_mem_rd", word_t'(out_mem_rd), word_t'(e.mem_rd));
            compare("out_mem_wr", word_t'(out_mem_wr), word_t'(e.mem_wr));
            compare("out_mem_addr", out_mem_addr, e.mem_addr);
            if (e.chk_data) begin
               compare("out_a", out_a, e.a);
               compare("out_b", out_b, e.b);
               compare("out_dr", word_t'(out_dr), word_t'(e.dr));
            end
         end
      end
   end

   task automatic issue(input ir_t w, input word_t eip, input exp_t e);
      @(posedge CLK);
      ir_valid <= 1'b1;
      ir       <= w;
      ir_eip   <= eip;
      exp_q.push_back(e);
      issued++;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge CLK);
         ir_valid <= 1'b0;
      end
   endtask

   task automatic drain();
      int waited;
      idle(1);
      waited = 0;
      while (exp_q.size() != 0 && waited < 20) begin
         @(posedge CLK);
         waited++;
      end
      if (exp_q.size() != 0) begin
         $display("Timeout: %0d results never arrived", exp_q.size());
         timed_out = 1'b1;
         errors++;
      end
   endtask

   task automatic load_registers();
      word_t v;
      for (int i = 0; i < 8; i++) begin
         v = rand_bits(32);
         @(posedge CLK);
         gpr_we       <= 1'b1;
         gpr_wr_id    <= reg_id_t'(i);
         gpr_din      <= v;
         gpr_model[i] = v;
      end
      @(posedge CLK);
      gpr_we <= 1'b0;
   endtask

   // Test 6 mixes all classes with random idle gaps
   task automatic run_test(input int id, input string name, input int n);
      ir_t   w;
      word_t eip;
      exp_t  e;
      int    err0;
      int    res0;
      int    kind;
      if (timed_out) return;
      err0 = errors;
      res0 = results;
      for (int i = 0; i < n; i++) begin
         kind = (id == 6) ? 1 + int'(rand_bits(3) % 5) : id;
         make_insn(kind, w, eip, e);
         issue(w, eip, e);
         if (id == 6 && rand_bits(2) == 0) idle(1 + int'(rand_bits(2)));
      end
      drain();
      if (results - res0 != n) begin
         $display("Test %0d gave %0d results for %0d instructions", id, results - res0, n);
         errors++;
      end
      $display("test %0d %s: %0d issued, %0d results, %0d errors",
               id, name, n, results - res0, errors - err0);
   endtask

   initial begin
      rst_n     = 1'b0;
      ir_valid  = 1'b0;
      ir        = '0;
      ir_eip    = '0;
      gpr_we    = 1'b0;
      gpr_wr_id = '0;
      gpr_din   = '0;
      lfsr      = 16'd97;
      repeat (16) @(posedge CLK);
      rst_n <= 1'b1;
      load_registers();
      run_test(1, "register forms", 40);
      run_test(2, "memory forms", 60);
      run_test(3, "sib forms", 60);
      run_test(4, "immediate forms", 40);
      run_test(5, "unknown opcodes", 30);
      run_test(6, "mixed back to back", 200);
      $display("issued %0d, results %0d, checks %0d, errors %0d",
               issued, results, checks, errors);
      if (errors == 0 && results == issued) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule
